// ==== sim.f ====
+incdir+.
orbPkg.sv
orbChanIf.sv
orbInSync.sv
orbPackCtrl.sv
orbChanPacker.sv
orbFrameRam.sv
orbPackTop.sv
orbPack_checker.sv
orbPackTb.sv

// ==== run.sh ====
#!/bin/sh
# build the packer testbench with Verilator, run it and judge the log

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module orbPackTb \
	-o orbPackSim || { echo "build failed"; exit 1; }

# a run stopped by an assertion never reaches the closing message
./obj_dir/orbPackSim > sim.log 2>&1 || echo "test failed" >> sim.log
cat sim.log

grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

// ==== orbPackTb.sv ====
`timescale 1ns/1ns
`include "orb_cfg.svh"

module orbPackTb;
	import orbPkg::*;

	localparam int memWords = 2 ** `ORB_ADDR_W;
	localparam int blockCount = memWords / `ORB_BLOCK_WORDS;

	logic clk;
	logic rst;
	logic [`ORB_DATA_W-1:0] data1;
	logic [`ORB_DATA_W-1:0] data2;
	logic strobe1;
	logic strobe2;
	logic sw;
	orbAddr_t rdAddr;
	orbWord_t word1;
	orbWord_t word2;
	orbAddr_t addr1;
	orbAddr_t addr2;
	logic we1;
	logic we2;
	logic restartFlag;
	orbWord_t rdData;

	int errors;
	int timeouts;

	// reference model of the block schedule, index 0 is channel 1
	int wordCnt [2];
	int slotCnt [2];
	int blockCnt [2];
	orbWord_t expMem [memWords];
	bit expValid [memWords];

	orbPackTop orbPackTop_i (
		.clk(clk),
		.rst(rst),
		.data1(data1),
		.data2(data2),
		.strobe1(strobe1),
		.strobe2(strobe2),
		.sw(sw),
		.rdAddr(rdAddr),
		.word1(word1),
		.word2(word2),
		.addr1(addr1),
		.addr2(addr2),
		.we1(we1),
		.we2(we2),
		.restartFlag(restartFlag),
		.rdData(rdData)
	);

	always #20 clk = ~clk;

	function automatic logic weOf(input int ch);
		return (ch == 0) ? we1 : we2;
	endfunction

	function automatic orbWord_t wordOf(input int ch);
		return (ch == 0) ? word1 : word2;
	endfunction

	function automatic orbAddr_t addrOf(input int ch);
		return (ch == 0) ? addr1 : addr2;
	endfunction

	function automatic int dataWordsOf(input int ch);
		return (ch == 0) ? 16 : 15;  // channel 2 spends one more strobe on gaps
	endfunction

	function automatic logic [`ORB_DATA_W-1:0] randByte();
		int r;
		r = $urandom();
		return r[`ORB_DATA_W-1:0];
	endfunction

	task automatic driveInputs(input int ch, input logic s, input logic [`ORB_DATA_W-1:0] b);
		if (ch == 0) begin
			strobe1 = s;
			data1 = b;
		end else begin
			strobe2 = s;
			data2 = b;
		end
	endtask

	task automatic clearModel();
		for (int i = 0; i < 2; i++) begin
			wordCnt[i] = 0;
			slotCnt[i] = 0;
			blockCnt[i] = 0;
		end
	endtask

	task automatic sendByte(input int ch, input logic [`ORB_DATA_W-1:0] b);
		bit isData;
		bit isEnd;
		bit weSeen;
		int cnt;
		orbWord_t expWord;
		orbAddr_t expAddr;

		isData = wordCnt[ch] < dataWordsOf(ch);
		isEnd = (wordCnt[ch] == 17);
		expWord = {1'b0, b, 3'b000};
		expAddr = orbAddr_t'(blockCnt[ch] * `ORB_BLOCK_WORDS + slotCnt[ch] * 2 + ch);
		driveInputs(ch, 1'b1, b);
		if (isData) begin
			cnt = 0;
			while (!weOf(ch) && cnt < 100) begin
				@(posedge clk);
				#2;
				cnt++;
			end
			if (!weOf(ch)) begin
				timeouts++;
				$display("channel %0d: write enable did not rise within 100 cycles", ch + 1);
			end else begin
				if (wordOf(ch) !== expWord) begin
					errors++;
					$display("Fail at %0t: channel %0d word %h, expected %h",
						$time, ch + 1, wordOf(ch), expWord);
				end
				if (addrOf(ch) !== expAddr) begin
					errors++;
					$display("Fail at %0t: channel %0d addr %0d, expected %0d",
						$time, ch + 1, addrOf(ch), expAddr);
				end
				expMem[expAddr] = expWord;
				expValid[expAddr] = 1'b1;
			end
			repeat (40) @(posedge clk);
			#2;
		end else begin
			weSeen = 1'b0;
			repeat (40) begin
				@(posedge clk);
				#2;
				weSeen = weSeen | weOf(ch);
			end
			if (weSeen) begin
				errors++;
				$display("Fail at %0t: channel %0d write enable high on a gap or end strobe",
					$time, ch + 1);
			end
		end
		driveInputs(ch, 1'b0, b);
		cnt = 0;
		while (weOf(ch) && cnt < 20) begin
			@(posedge clk);
			#2;
			cnt++;
		end
		if (weOf(ch)) begin
			timeouts++;
			$display("channel %0d: write enable stayed high after the strobe dropped", ch + 1);
		end
		// synchronizer and FSM need a few clocks to see the strobe low
		repeat (4) @(posedge clk);
		#2;
		wordCnt[ch]++;
		if (isData) begin
			slotCnt[ch] = (slotCnt[ch] == dataWordsOf(ch) - 1) ? 0 : slotCnt[ch] + 1;
		end else if (isEnd) begin
			blockCnt[ch] = (blockCnt[ch] + 1) % blockCount;
			wordCnt[ch] = 0;
		end
	endtask

	task automatic checkMemory();
		for (int a = 0; a < memWords; a++) begin
			if (expValid[a]) begin
				rdAddr = orbAddr_t'(a);
				@(posedge clk);
				#2;
				if (rdData !== expMem[a]) begin
					errors++;
					$display("Fail at %0t: memory[%0d] reads %h, expected %h",
						$time, a, rdData, expMem[a]);
				end
			end
		end
	endtask

	task automatic checkReset();
		if (we1 !== 1'b0 || we2 !== 1'b0 || restartFlag !== 1'b0) begin
			errors++;
			$display("Fail at %0t: we1, we2 or restartFlag not low after reset", $time);
		end
		if (word1 !== '0 || word2 !== '0 || addr1 !== '0 || addr2 !== '0) begin
			errors++;
			$display("Fail at %0t: word or addr not zero after reset", $time);
		end
	endtask

	task automatic runBlock(input int ch);
		repeat (18) begin
			sendByte(ch, randByte());
		end
		checkMemory();
	endtask

	task automatic testBlockAdvance();
		sendByte(0, randByte());
		if (addr1 !== orbAddr_t'(`ORB_BLOCK_WORDS)) begin
			errors++;
			$display("Fail at %0t: second block starts at addr %0d, expected %0d",
				$time, addr1, `ORB_BLOCK_WORDS);
		end
		repeat (17) begin
			sendByte(0, randByte());
		end
		checkMemory();
	endtask

	task automatic testRestart();
		int cnt;
		int pulses;

		repeat (5) sendByte(0, randByte());
		repeat (4) sendByte(1, randByte());
		sw = ~sw;
		cnt = 0;
		while (!restartFlag && cnt < 10) begin
			@(posedge clk);
			#2;
			cnt++;
		end
		if (!restartFlag) begin
			timeouts++;
			$display("restartFlag did not rise after the switch toggle");
		end
		pulses = 0;
		repeat (8) begin
			if (restartFlag) pulses++;
			@(posedge clk);
			#2;
		end
		if (pulses != 1) begin
			errors++;
			$display("Fail at %0t: restartFlag high for %0d cycles, expected 1", $time, pulses);
		end
		clearModel();
		sendByte(0, randByte());
		sendByte(1, randByte());
		if (addr1 !== orbAddr_t'(0) || addr2 !== orbAddr_t'(1)) begin
			errors++;
			$display("Fail at %0t: addresses %0d and %0d after restart, expected 0 and 1",
				$time, addr1, addr2);
		end
	endtask

	task automatic testBothChannels();
		logic [`ORB_DATA_W-1:0] b0;
		logic [`ORB_DATA_W-1:0] b1;

		repeat (18) begin
			b0 = randByte();
			b1 = randByte();
			fork
				sendByte(0, b0);
				sendByte(1, b1);
			join
		end
		checkMemory();
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		data1 = '0;
		data2 = '0;
		strobe1 = 1'b0;
		strobe2 = 1'b0;
		sw = 1'b0;
		rdAddr = '0;
		errors = 0;
		timeouts = 0;
		void'($urandom(32'hf11008d7));
		clearModel();
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b1;
		@(posedge clk);
		#2;
		checkReset();
		runBlock(0);
		runBlock(1);
		testBlockAdvance();
		testRestart();
		testBothChannels();
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== orbPack_checker.sv ====
`timescale 1ns/1ns

module orbPackChecker (
	input logic clk,
	input logic rst,
	input logic restart,
	input orbPkg::chanState_t state0,
	input orbPkg::chanState_t state1,
	input logic we0,
	input logic we1
);
	import orbPkg::*;

	// WAIT clears we on the same edge that returns to IDLE
	idleNoWe0: assert property (@(posedge clk) disable iff (!rst) (state0 == IDLE) |-> !we0)
		else $error("channel 1 write enable high in IDLE");
	idleNoWe1: assert property (@(posedge clk) disable iff (!rst) (state1 == IDLE) |-> !we1)
		else $error("channel 2 write enable high in IDLE");

	restartOnce: assert property (@(posedge clk) disable iff (!rst) restart |=> !restart)
		else $error("restart held longer than one cycle");

	weRise0: assert property (@(posedge clk) disable iff (!rst) $rose(we0) |-> $past(state0) == WESET)
		else $error("channel 1 write enable rose outside WESET");
	weRise1: assert property (@(posedge clk) disable iff (!rst) $rose(we1) |-> $past(state1) == WESET)
		else $error("channel 2 write enable rose outside WESET");

endmodule

bind orbPackCtrl orbPackChecker orbPackChecker_i (
	.clk(clk),
	.rst(rst),
	.restart(restart),
	.state0(gChan[0].state),
	.state1(gChan[1].state),
	.we0(chan[0].we),
	.we1(chan[1].we)
);

// ==== orbPackTop.sv ====
`timescale 1ns/1ns
`include "orb_cfg.svh"

module orbPackTop (
	input logic clk,
	input logic rst,
	input logic [`ORB_DATA_W-1:0] data1,
	input logic [`ORB_DATA_W-1:0] data2,
	input logic strobe1,
	input logic strobe2,
	input logic sw,
	input orbPkg::orbAddr_t rdAddr,
	output orbPkg::orbWord_t word1,
	output orbPkg::orbWord_t word2,
	output orbPkg::orbAddr_t addr1,
	output orbPkg::orbAddr_t addr2,
	output logic we1,
	output logic we2,
	output logic restartFlag,
	output orbPkg::orbWord_t rdData
);
	import orbPkg::*;

	logic strobeIn [2];
	logic strobe [2];
	logic weArr [2];
	orbAddr_t wrAddr [2];
	orbWord_t wrData [2];

	orbChanIf chanIf [2] ();

	assign strobeIn[0] = strobe1;
	assign strobeIn[1] = strobe2;

	orbInSync orbInSync_i (
		.clk(clk),
		.rst(rst),
		.strobeIn(strobeIn),
		.swIn(sw),
		.strobe(strobe),
		.restart(restartFlag)
	);

	orbPackCtrl orbPackCtrl_i (
		.clk(clk),
		.rst(rst),
		.strobe(strobe),
		.restart(restartFlag),
		.chan(chanIf)
	);

	// channel 1 owns the even slots
	orbChanPacker #(.dataWords(16), .addrOdd(1'b0)) orbChanPacker1_i (
		.clk(clk),
		.rst(rst),
		.data(data1),
		.ch(chanIf[0]),
		.word(word1),
		.addr(addr1)
	);

	orbChanPacker #(.dataWords(15), .addrOdd(1'b1)) orbChanPacker2_i (
		.clk(clk),
		.rst(rst),
		.data(data2),
		.ch(chanIf[1]),
		.word(word2),
		.addr(addr2)
	);

	assign we1 = chanIf[0].we;
	assign we2 = chanIf[1].we;

	assign weArr[0] = we1;
	assign weArr[1] = we2;
	assign wrAddr[0] = addr1;
	assign wrAddr[1] = addr2;
	assign wrData[0] = word1;
	assign wrData[1] = word2;

	orbFrameRam orbFrameRam_i (
		.clk(clk),
		.we(weArr),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

endmodule

// ==== orbFrameRam.sv ====
`timescale 1ns/1ns
`include "orb_cfg.svh"

module orbFrameRam (
	input logic clk,
	input logic we [2],
	input orbPkg::orbAddr_t wrAddr [2],
	input orbPkg::orbWord_t wrData [2],
	input orbPkg::orbAddr_t rdAddr,
	output orbPkg::orbWord_t rdData
);
	import orbPkg::*;

	localparam int depth = 2 ** `ORB_ADDR_W;

	orbWord_t mem [depth];

	// channel 1 writes even and channel 2 odd addresses, so the ports never collide
	always_ff @(posedge clk) begin
		if (we[0]) begin
			mem[wrAddr[0]] <= wrData[0];
		end
		if (we[1]) begin
			mem[wrAddr[1]] <= wrData[1];
		end
	end

	always_ff @(posedge clk) begin
		rdData <= mem[rdAddr];  // one cycle read latency
	end

endmodule

// ==== orbChanPacker.sv ====
`timescale 1ns/1ns
`include "orb_cfg.svh"

module orbChanPacker #(
	parameter int dataWords = 16,
	parameter bit addrOdd = 1'b0
) (
	input logic clk,
	input logic rst,
	input logic [`ORB_DATA_W-1:0] data,
	orbChanIf.dp ch,
	output orbPkg::orbWord_t word,
	output orbPkg::orbAddr_t addr
);
	import orbPkg::*;

	localparam int slotBits = $clog2(`ORB_BLOCK_WORDS) - 1;
	localparam int blockBits = `ORB_ADDR_W - $clog2(`ORB_BLOCK_WORDS);
	localparam int padBits = `ORB_WORD_W - `ORB_DATA_W - 1;
	localparam logic [4:0] endCount = 5'd17;  // last strobe of every block
	localparam logic [slotBits-1:0] lastSlot = slotBits'(dataWords - 1);

	logic [4:0] wordCnt;  // strobes taken in this block
	logic [slotBits-1:0] slotCnt;
	logic [blockBits-1:0] blockCnt;

	always_comb begin
		if (wordCnt < 5'(dataWords)) begin
			ch.slotKind = SLOT_DATA;
		end else if (wordCnt == endCount) begin
			ch.slotKind = SLOT_END;
		end else begin
			ch.slotKind = SLOT_GAP;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wordCnt <= '0;
			slotCnt <= '0;
			blockCnt <= '0;
			word <= '0;
			addr <= '0;
		end else if (ch.restart) begin
			wordCnt <= '0;
			slotCnt <= '0;
			blockCnt <= '0;
		end else if (ch.load) begin
			wordCnt <= wordCnt + 5'd1;
			case (ch.slotKind)
				SLOT_DATA: begin
					word <= {1'b0, data, {padBits{1'b0}}};
					// 32 * block + 2 * slot + channel parity
					addr <= {blockCnt, slotCnt, addrOdd};
					if (slotCnt == lastSlot) begin
						slotCnt <= '0;
					end else begin
						slotCnt <= slotCnt + 1'b1;
					end
				end
				SLOT_END: begin
					blockCnt <= blockCnt + 1'b1;
					wordCnt <= '0;
				end
				default: begin
					// gap strobe only moves the word counter
				end
			endcase
		end
	end

endmodule

// ==== orbPackCtrl.sv ====
`timescale 1ns/1ns
`include "orb_cfg.svh"

module orbPackCtrl (
	input logic clk,
	input logic rst,
	input logic strobe [2],
	input logic restart,
	orbChanIf.ctrl chan [2]
);
	import orbPkg::*;

	localparam logic [4:0] weSet = 5'(`ORB_WE_SET);
	localparam logic [4:0] weEnd = 5'(`ORB_WE_END);

	genvar i;

	generate
		for (i = 0; i < 2; i++) begin : gChan
			chanState_t state;
			logic [4:0] weCnt;  // cycles since the load of a data word

			// only the first cycle of a strobe in IDLE counts as a load
			assign chan[i].load = (state == IDLE) && strobe[i];
			assign chan[i].restart = restart;

			always_ff @(posedge clk or negedge rst) begin
				if (!rst) begin
					state <= IDLE;
					weCnt <= 5'd0;
					chan[i].we <= 1'b0;
				end else begin
					case (state)
						IDLE: begin
							if (strobe[i]) begin
								weCnt <= 5'd0;
								// gap and end strobes never write
								if (chan[i].slotKind == SLOT_DATA) begin
									state <= WESET;
								end else begin
									state <= WAIT;
								end
							end
						end
						WESET: begin
							weCnt <= weCnt + 5'd1;
							if (weCnt == weSet) begin
								chan[i].we <= 1'b1;  // word and address long settled by now
							end else if (weCnt == weEnd) begin
								state <= WAIT;
							end
						end
						WAIT: begin
							if (!strobe[i]) begin
								chan[i].we <= 1'b0;
								state <= IDLE;
							end
						end
						default: begin
							state <= IDLE;
						end
					endcase

					// a frame restart leaves the state alone
					if (restart) begin
						weCnt <= 5'd0;
					end
				end
			end
		end
	endgenerate

endmodule

// ==== orbInSync.sv ====
`timescale 1ns/1ns

module orbInSync (
	input logic clk,
	input logic rst,
	input logic strobeIn [2],
	input logic swIn,
	output logic strobe [2],
	output logic restart
);

	logic [1:0] strobeSync [2];
	logic [1:0] swSync;
	logic swOld;  // last synchronized switch level

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < 2; i++) begin
				strobeSync[i] <= 2'b00;
			end
			swSync <= 2'b00;
			swOld <= 1'b0;
			restart <= 1'b0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				strobeSync[i] <= {strobeSync[i][0], strobeIn[i]};
			end
			swSync <= {swSync[0], swIn};
			swOld <= swSync[1];
			// either edge of the switch restarts the frame
			restart <= swSync[1] ^ swOld;
		end
	end

	assign strobe[0] = strobeSync[0][1];
	assign strobe[1] = strobeSync[1][1];

endmodule

// ==== orbChanIf.sv ====
`timescale 1ns/1ns

interface orbChanIf;
	import orbPkg::*;

	logic load;  // one cycle, datapath takes the strobe on it
	logic restart;  // one cycle, clears the datapath counters
	slotKind_t slotKind;
	logic we;  // level, held until the strobe drops

	modport ctrl (
		output load,
		output restart,
		output we,
		input slotKind
	);

	modport dp (
		input load,
		input restart,
		output slotKind
	);

endinterface

// ==== orbPkg.sv ====
`include "orb_cfg.svh"

package orbPkg;

	// per-channel control state
	typedef enum logic [1:0] {
		IDLE,
		WESET,  // waiting for the write enable delay to run out
		WAIT
	} chanState_t;

	// what the current strobe means, taken from the word counter
	typedef enum logic [1:0] {
		SLOT_DATA,
		SLOT_GAP,
		SLOT_END
	} slotKind_t;

	typedef logic [`ORB_WORD_W-1:0] orbWord_t;
	typedef logic [`ORB_ADDR_W-1:0] orbAddr_t;

endpackage

// ==== orb_cfg.svh ====
`ifndef ORB_CFG_SVH
`define ORB_CFG_SVH

// width of one byte from a serial source
`define ORB_DATA_W 8

// frame word: one zero bit, the byte, three zero bits
`define ORB_WORD_W 12

// frame memory holds 2048 words
`define ORB_ADDR_W 11

// words per block, even and odd slots interleaved
`define ORB_BLOCK_WORDS 32

// delay counter values in WESET
`define ORB_WE_SET 28
`define ORB_WE_END 31

`endif
